/* src.f */
+incdir+.
eval_pkg.sv
eval_control.sv
rank_scanner.sv
phase_blend.sv
board_evaluator.sv
tb_board_evaluator.sv

/* run.sh */
#!/bin/sh
# Build and run the board evaluator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f src.f --top-module tb_board_evaluator -o tb_board_evaluator
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_board_evaluator > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
   echo "Simulation FAILED"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

echo "Simulation PASSED"
exit 0

/* tb_board_model.svh */
//////////////////////////////////////////
// Reference evaluation model
//////////////////////////////////////////

`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// Midgame material by piece type
function automatic int mg_value(input logic [2:0] kind);
   case (kind)
      3'd1:    return 82;                    // Pawn
      3'd2:    return 337;                   // Knight
      3'd3:    return 365;                   // Bishop
      3'd4:    return 477;                   // Rook
      3'd5:    return 1025;                  // Queen
      default: return 0;                     // Empty, king, unused code
   endcase
endfunction

// Endgame material by piece type
function automatic int eg_value(input logic [2:0] kind);
   case (kind)
      3'd1:    return 94;
      3'd2:    return 281;
      3'd3:    return 297;
      3'd4:    return 512;
      3'd5:    return 936;
      default: return 0;
   endcase
endfunction

// Expected eval of a whole board, white positive
function automatic int expected_eval_of(input logic [255:0] b);
   logic [3:0] code;
   logic [2:0] kind;
   int         sign;
   int         mg;
   int         eg;
   int         pieces;                       // Non-empty non-pawn squares
   int         phase;
   longint     blended;
   mg     = 0;
   eg     = 0;
   pieces = 0;
   for (int n = 0; n < 64; n++)
   begin
      code = b[4*n +: 4];
      kind = code[2:0];
      sign = code[3] ? -1 : 1;               // Black subtracts
      mg   = mg + sign * mg_value(kind);
      eg   = eg + sign * eg_value(kind);
      if (kind >= 3'd2 && kind <= 3'd6)
         pieces = pieces + 1;
   end
   phase   = (pieces > 62) ? 62 : pieces;    // Clamp
   blended = longint'(mg * phase + eg * (62 - phase));
   // Division of signed values truncates toward zero
   return int'((blended * longint'(16912)) / longint'(1048576));
endfunction

`endif

/* tb_board_evaluator.sv */
//////////////////////////////////////////
// Board evaluator testbench
//////////////////////////////////////////

`timescale 1ns/1ps

module tb_board_evaluator;

   import eval_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int NUM_RANDOM   = 36;
   localparam int NUM_BOARDS   = NUM_RANDOM + 4;    // Four fixed positions first
   localparam int BOARD_CYCLES = 40;                // Generous per-board budget
   localparam int HOLD_CYCLES  = 18;                // Longer than a full 8-square evaluation

   logic      clk;
   logic      reset;
   logic      board_valid;
   board_t    board_in;
   logic      clear_eval;
   score_t    eval;
   logic      eval_valid;
   score_t    expected_eval;                        // Model value of accepted board
   logic      armed;                                // Accepted edge, result not yet cleared

   `include "tb_board_model.svh"

   board_evaluator board_evaluator_i
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      stop_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
   endtask

   // No result without an open start, covers reset and held board_valid
   a_no_result_unarmed: assert property (@(posedge clk) disable iff (reset)
      !armed && !$past(armed) |-> !eval_valid)
      else report_mismatch("eval_valid high without an accepted start");

   a_eval_value: assert property (@(posedge clk) disable iff (reset)
      $rose(eval_valid) |-> eval == expected_eval)
      else report_mismatch($sformatf("eval %0d, expected %0d", $sampled(eval), expected_eval));

   a_result_held: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid && $stable(eval))
      else report_mismatch("result not held while clear_eval low");

   a_clear_drops: assert property (@(posedge clk) disable iff (reset)
      eval_valid && clear_eval |=> !eval_valid)
      else report_mismatch("eval_valid still high after clear_eval");

   function automatic board_t starting_position();
      logic [3:0] back_rank [8];
      board_t     b;
      back_rank = '{4'd4, 4'd2, 4'd3, 4'd5, 4'd6, 4'd3, 4'd2, 4'd4};   // R N B Q K B N R
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[4*f +: 4]      = back_rank[f];
         b[4*(8+f) +: 4]  = 4'd1;                   // White pawns
         b[4*(48+f) +: 4] = 4'd9;                   // Black pawns
         b[4*(56+f) +: 4] = back_rank[f] | 4'd8;
      end
      return b;
   endfunction

   // Every square a non-pawn piece, phase above the clamp
   function automatic board_t full_board();
      board_t     b;
      logic [3:0] code;
      for (int n = 0; n < 64; n++)
      begin
         code = 4'(2 + n % 5);
         if (((n / 8) + n) % 2 == 1)
            code[3] = 1'b1;
         b[4*n +: 4] = code;
      end
      return b;
   endfunction

   function automatic board_t random_board();
      board_t     b;
      logic [3:0] code;
      b = '0;
      for (int n = 0; n < 64; n++)
      begin
         if ($urandom % 2 == 1)                     // Half the squares occupied
         begin
            code = 4'(1 + $urandom % 6);
            if ($urandom % 2 == 1)
               code[3] = 1'b1;
            b[4*n +: 4] = code;
         end
      end
      return b;
   endfunction

   // One evaluation, optionally with a second edge and new board while busy
   task automatic run_board(input board_t b, input logic disturb);
      int hold;
      board_in      = b;
      board_valid   = 1'b1;                         // Rising edge in IDLE
      expected_eval = score_t'(expected_eval_of(b));
      armed         = 1'b1;
      if (disturb)
      begin
         @(negedge clk);
         board_valid = 1'b0;
         board_in    = random_board();
         @(negedge clk);
         board_valid = 1'b1;                        // Ignored edge
         board_in    = ~b;
      end
      while (!eval_valid)
         @(negedge clk);
      hold = $urandom % 11;
      repeat (hold) @(negedge clk);
      clear_eval = 1'b1;
      armed      = 1'b0;
      @(negedge clk);
      clear_eval = 1'b0;
      repeat (HOLD_CYCLES) @(negedge clk);          // board_valid still high
      board_valid = 1'b0;
      @(negedge clk);
   endtask

   initial
   begin
      #(NUM_BOARDS * (BOARD_CYCLES + HOLD_CYCLES) * CLK_PERIOD + 100 * CLK_PERIOD);
      stop_run("Timeout: the evaluator did not deliver all results in time");
   end

   initial
   begin
      board_t b;
      void'($urandom(89));
      clk           = 1'b0;
      reset         = 1'b1;
      board_valid   = 1'b0;
      board_in      = '0;
      clear_eval    = 1'b0;
      armed         = 1'b0;
      expected_eval = '0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);
      run_board('0, 1'b0);                          // Empty board
      run_board(starting_position(), 1'b1);
      run_board(full_board(), 1'b0);
      b = starting_position();
      b[0 +: 4]  = 4'd0;                            // White loses a1 rook
      b[12 +: 4] = 4'd0;                            // and the queen
      b[28 +: 4] = 4'd0;                            // and h1 rook
      run_board(b, 1'b0);
      for (int i = 0; i < NUM_RANDOM; i++)
         run_board(random_board(), (i % 2 == 1));
      repeat (3) @(negedge clk);
      $display("Done: no errors");
      $finish;
   end

endmodule

/* board_evaluator.sv */
//////////////////////////////////////////
// Board evaluator top level
//////////////////////////////////////////

`timescale 1ns/1ps

module board_evaluator
(
   input  logic                clk,
   input  logic                reset,
   input  logic                board_valid,
   input  eval_pkg::board_t    board_in,
   input  logic                clear_eval,
   output eval_pkg::score_t    eval,
   output logic                eval_valid
);

   import eval_pkg::*;

   board_t        board;                   // Frozen board from controller
   logic          scan_start;
   lane_mask_t    scan_done;
   score_t        lane_mg [NUM_RANKS];
   score_t        lane_eg [NUM_RANKS];
   count_t        lane_count [NUM_RANKS];

   eval_control eval_control_i
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .scan_done   (scan_done),
      .board       (board),
      .scan_start  (scan_start),
      .eval_valid  (eval_valid)
   );

   // One scanner per rank, all started together
   for (genvar i = 0; i < NUM_RANKS; i++)
   begin : rank_scanner_g
      rank_scanner rank_scanner_i
      (
         .clk        (clk),
         .reset      (reset),
         .scan_start (scan_start),
         .board      (board),
         .rank_index (3'(i)),
         .lane_mg    (lane_mg[i]),
         .lane_eg    (lane_eg[i]),
         .lane_count (lane_count[i]),
         .scan_done  (scan_done[i])
      );
   end

   phase_blend phase_blend_i
   (
      .clk        (clk),
      .lane_mg    (lane_mg),
      .lane_eg    (lane_eg),
      .lane_count (lane_count),
      .eval       (eval)
   );

endmodule

/* phase_blend.sv */
//////////////////////////////////////////
// Midgame/endgame phase blend
//////////////////////////////////////////

`timescale 1ns/1ps

module phase_blend
(
   input  logic                clk,
   input  eval_pkg::score_t    lane_mg [eval_pkg::NUM_RANKS],
   input  eval_pkg::score_t    lane_eg [eval_pkg::NUM_RANKS],
   input  eval_pkg::count_t    lane_count [eval_pkg::NUM_RANKS],
   output eval_pkg::score_t    eval
);

   import eval_pkg::*;

   score_t    mg_sum;              // Lane totals, combinational
   score_t    eg_sum;
   count_t    count_sum;
   score_t    mg_t1;
   score_t    eg_t1;
   count_t    phase_t1;            // Clamped non-pawn count
   blend_t    prod_mg_t2;
   blend_t    prod_eg_t2;
   blend_t    sum_t3;
   blend_t    scaled_t4;           // Sum times 2^20/62
   blend_t    round_bias;          // Makes the shift truncate toward zero

   // Adder tree over the lanes
   always_comb
   begin
      mg_sum    = '0;
      eg_sum    = '0;
      count_sum = '0;
      for (int r = 0; r < NUM_RANKS; r++)
      begin
         mg_sum    = mg_sum + lane_mg[r];
         eg_sum    = eg_sum + lane_eg[r];
         count_sum = count_sum + lane_count[r];
      end
   end

   // Stage 1, totals and phase clamp
   always_ff @(posedge clk)
   begin
      mg_t1 <= mg_sum;
      eg_t1 <= eg_sum;
      if (count_sum > count_t'(PHASE_MAX))
         phase_t1 <= count_t'(PHASE_MAX);
      else
         phase_t1 <= count_sum;
   end

   // Stage 2, weight each half by phase
   always_ff @(posedge clk)
   begin
      prod_mg_t2 <= blend_t'(mg_t1) * blend_t'(phase_t1);
      prod_eg_t2 <= blend_t'(eg_t1) * blend_t'(count_t'(PHASE_MAX) - phase_t1);
   end

   // Stage 3
   always_ff @(posedge clk)
   begin
      sum_t3 <= prod_mg_t2 + prod_eg_t2;
   end

   // Stage 4, reciprocal multiply in place of divide by 62
   always_ff @(posedge clk)
   begin
      scaled_t4 <= sum_t3 * blend_t'(RECIP_62);
   end

   // Negative values need 2^20 - 1 added before the arithmetic shift
   assign round_bias = scaled_t4[$bits(blend_t)-1] ?
                       blend_t'((1 << RECIP_SHIFT) - 1) : '0;

   // Stage 5
   always_ff @(posedge clk)
   begin
      eval <= score_t'((scaled_t4 + round_bias) >>> RECIP_SHIFT);
   end

endmodule

/* rank_scanner.sv */
//////////////////////////////////////////
// Serial rank material scanner
//////////////////////////////////////////

`timescale 1ns/1ps

module rank_scanner
(
   input  logic                clk,
   input  logic                reset,
   input  logic                scan_start,
   input  eval_pkg::board_t    board,
   input  logic [2:0]          rank_index,
   output eval_pkg::score_t    lane_mg,
   output eval_pkg::score_t    lane_eg,
   output eval_pkg::count_t    lane_count,
   output logic                scan_done
);

   import eval_pkg::*;

   rank_t                          rank_load;     // This lane's slice of the board
   logic [SQUARES_PER_RANK-1:0]    occ_load;      // Occupied squares at load
   rank_t                          rank_sh;       // Current square in low nibble
   logic [SQUARES_PER_RANK-1:0]    occ_sh;        // Occupancy still to visit
   logic                           busy;
   piece_t                         square;
   piece_type_t                    square_type;
   logic                           last_square;

   assign rank_load = board[rank_index * RANK_WIDTH +: RANK_WIDTH];

   always_comb
   begin
      for (int f = 0; f < SQUARES_PER_RANK; f++)
      begin
         // Codes 7 and 15 count as empty
         occ_load[f] = (rank_load[f * PIECE_WIDTH +: 3] != PT_EMPTY) &&
                       (rank_load[f * PIECE_WIDTH +: 3] != PT_NONE);
      end
   end

   assign square      = rank_sh[PIECE_WIDTH-1:0];
   assign square_type = piece_type_t'(square[2:0]);
   assign last_square = (occ_sh[SQUARES_PER_RANK-1:1] == '0);  // Rest of rank empty

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         scan_done <= 1'b0;
      end
      else
      begin
         scan_done <= 1'b0;
         if (scan_start)
            busy <= 1'b1;
         else if (busy && last_square)
         begin
            busy      <= 1'b0;                            // Early finish
            scan_done <= 1'b1;
         end
      end
   end

   // Accumulators double as the held lane results
   always_ff @(posedge clk)
   begin
      if (scan_start)
      begin
         rank_sh    <= rank_load;
         occ_sh     <= occ_load;
         lane_mg    <= '0;
         lane_eg    <= '0;
         lane_count <= '0;
      end
      else if (busy)
      begin
         rank_sh <= rank_sh >> PIECE_WIDTH;               // Next file
         occ_sh  <= occ_sh >> 1;
         if (occ_sh[0])
         begin
            if (square[BLACK_BIT])
            begin
               lane_mg <= lane_mg - MG_VALUE[square_type];
               lane_eg <= lane_eg - EG_VALUE[square_type];
            end
            else
            begin
               lane_mg <= lane_mg + MG_VALUE[square_type];
               lane_eg <= lane_eg + EG_VALUE[square_type];
            end
            if (square_type != PT_PAWN)
               lane_count <= lane_count + 1'b1;           // Phase counts non-pawns only
         end
      end
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (reset)
      scan_done |=> !scan_done)
      else $error("scan_done longer than one cycle");

endmodule

/* eval_control.sv */
//////////////////////////////////////////
// Evaluation control FSM
//////////////////////////////////////////

`timescale 1ns/1ps

module eval_control
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_valid,
   input  eval_pkg::board_t       board_in,
   input  logic                   clear_eval,
   input  eval_pkg::lane_mask_t   scan_done,
   output eval_pkg::board_t       board,
   output logic                   scan_start,
   output logic                   eval_valid
);

   import eval_pkg::*;

   eval_state_t   state;
   logic          board_valid_r;       // Previous board_valid for edge detect
   logic          start;
   lane_mask_t    done_lock;           // Sticky per-lane done
   logic [2:0]    blend_count;         // Cycles spent in WAIT_BLEND
   logic          all_done;

   assign start = board_valid & ~board_valid_r;

   // Lock from the previous scan still reads set while scan_start is high
   assign all_done = &done_lock & ~scan_start;

   always_ff @(posedge clk)
   begin
      if (reset)
         board_valid_r <= 1'b0;
      else
         board_valid_r <= board_valid;
   end

   // Board tracks the input until a start is taken, then freezes
   always_ff @(posedge clk)
   begin
      if (state == IDLE)
         board <= board_in;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         done_lock <= '0;
      else if (scan_start)
         done_lock <= '0;                                // New scan, forget old dones
      else
         done_lock <= done_lock | scan_done;
   end

   // Lock register and WAIT_SCAN exit take two of the blend cycles,
   // and eval_valid rises on the same edge as the last pipeline stage
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= IDLE;
         scan_start  <= 1'b0;
         eval_valid  <= 1'b0;
         blend_count <= '0;
      end
      else
      begin
         scan_start <= 1'b0;                             // Single-cycle strobe
         case (state)
            IDLE:
            begin
               blend_count <= '0;
               if (start)
                  state <= WAIT_START;                   // Edges elsewhere ignored
            end
            WAIT_START:
            begin
               scan_start <= 1'b1;
               state      <= WAIT_SCAN;
            end
            WAIT_SCAN:
            begin
               if (all_done)
                  state <= WAIT_BLEND;
            end
            WAIT_BLEND:
            begin
               blend_count <= blend_count + 1'b1;
               if (blend_count == 3'(BLEND_LATENCY - 3))
               begin
                  state      <= WAIT_CLEAR;
                  eval_valid <= 1'b1;
               end
            end
            WAIT_CLEAR:
            begin
               if (clear_eval)
               begin
                  state      <= IDLE;
                  eval_valid <= 1'b0;                    // Drops the cycle after clear
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // Scanners are only kicked right after the settle cycle
   a_scan_start_slot: assert property (@(posedge clk) disable iff (reset)
      scan_start |-> $past(state) == WAIT_START)
      else $error("scan_start outside its slot");

   a_valid_in_clear: assert property (@(posedge clk) disable iff (reset)
      eval_valid |-> state == WAIT_CLEAR)
      else $error("eval_valid high outside WAIT_CLEAR");

endmodule

/* eval_pkg.sv */
//////////////////////////////////////////
// Position evaluator shared definitions
//////////////////////////////////////////

package eval_pkg;

   // Board geometry
   localparam int NUM_RANKS        = 8;                                 // One scanner lane per rank
   localparam int SQUARES_PER_RANK = 8;
   localparam int PIECE_WIDTH      = 4;                                 // Bits per square code
   localparam int RANK_WIDTH       = SQUARES_PER_RANK * PIECE_WIDTH;    // 32
   localparam int BOARD_WIDTH      = NUM_RANKS * RANK_WIDTH;            // 256
   localparam int BLACK_BIT        = 3;                                 // Colour bit in a square code

   // Phase blend constants
   localparam int PHASE_MAX     = 62;                                   // Phase clamp
   localparam int RECIP_62      = 16912;                                // 2^20 / 62, truncated
   localparam int RECIP_SHIFT   = 20;
   localparam int BLEND_LATENCY = 5;                                    // Blend pipeline depth

   typedef logic [PIECE_WIDTH-1:0]      piece_t;      // Bit 3 black, bits 2..0 type
   typedef logic [BOARD_WIDTH-1:0]      board_t;      // Square n at bits 4n+3..4n
   typedef logic [RANK_WIDTH-1:0]       rank_t;
   typedef logic signed [19:0]          score_t;      // Lane sums and final eval
   typedef logic [6:0]                  count_t;      // 0..64 pieces
   typedef logic signed [47:0]          blend_t;      // Blend products
   typedef logic [NUM_RANKS-1:0]        lane_mask_t;  // One bit per scanner

   // Piece type field of a square code
   typedef enum logic [2:0] {
      PT_EMPTY  = 3'd0,
      PT_PAWN   = 3'd1,
      PT_KNIGHT = 3'd2,
      PT_BISHOP = 3'd3,
      PT_ROOK   = 3'd4,
      PT_QUEEN  = 3'd5,
      PT_KING   = 3'd6,
      PT_NONE   = 3'd7                                                  // Unused, reads as empty
   } piece_type_t;

   // Material values by piece type, white positive
   localparam score_t MG_VALUE [8] = '{
      20'sd0,                                                           // Empty
      20'sd82,                                                          // Pawn
      20'sd337,                                                         // Knight
      20'sd365,                                                         // Bishop
      20'sd477,                                                         // Rook
      20'sd1025,                                                        // Queen
      20'sd0,                                                           // King
      20'sd0
   };

   localparam score_t EG_VALUE [8] = '{
      20'sd0, 20'sd94, 20'sd281, 20'sd297, 20'sd512, 20'sd936, 20'sd0, 20'sd0
   };

   // Controller states
   typedef enum logic [2:0] {
      IDLE,                                                             // Tracking board_in
      WAIT_START,                                                       // Captured board settles
      WAIT_SCAN,                                                        // Lanes scanning
      WAIT_BLEND,                                                       // Blend pipeline fills
      WAIT_CLEAR                                                        // Result held
   } eval_state_t;

endpackage
